// ==== source/looper_pkg.sv ====
package looper_pkg;

   localparam int data_w    = 16;
   localparam int pc_w      = 16;
   localparam int num_regs  = 8;
   localparam int reg_idx_w = 3;

   typedef logic [data_w-1:0]    data_t;
   typedef logic [pc_w-1:0]      pc_t;
   typedef logic [15:0]          inst_t;
   typedef logic [reg_idx_w-1:0] reg_idx_t;

   // instruction word
   //   [15:12] opcode  [11:9] rd  [8:6] rs1  [5:3] rs2
   //   addi takes imm6 from [5:0], ldi takes imm8 from [7:0]
   typedef enum logic [3:0] {
      op_nop  = 4'h0,
      op_add  = 4'h1,
      op_sub  = 4'h2,
      op_and  = 4'h3,
      op_or   = 4'h4,
      op_xor  = 4'h5,
      op_addi = 4'h6,
      op_ldi  = 4'h7,
      op_mul  = 4'h8
   } opcode_t;

   typedef enum logic [2:0] {
      alu_add  = 3'd0,
      alu_sub  = 3'd1,
      alu_and  = 3'd2,
      alu_or   = 3'd3,
      alu_xor  = 3'd4,
      alu_pass = 3'd5,
      alu_mul  = 3'd6
   } alu_mode_t;

   // fetch to decode
   typedef struct packed {
      logic  valid;
      pc_t   pc;
      inst_t inst;
   } fetch_t;

   // decode to execute
   typedef struct packed {
      logic      valid;
      alu_mode_t mode;
      reg_idx_t  rd;
      data_t     op_a;
      data_t     op_b;
   } exec_op_t;

   // execute result, also the write-back port
   typedef struct packed {
      logic     valid;
      reg_idx_t dst;
      data_t    data;
   } wb_result_t;

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall,
   input  looper_pkg::pc_t   extern_pc,
   input  logic              extern_pc_en,
   input  looper_pkg::inst_t inst_data,
   output looper_pkg::pc_t   inst_addr,
   output looper_pkg::fetch_t fetch,
   output logic              pc_change
);
   import looper_pkg::*;

   pc_t pc;
   pc_t pc_next;

   assign pc_next = pc + pc_t'(1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (extern_pc_en) begin
         pc <= extern_pc;
      end else if (!stall) begin
         pc <= pc_next;
      end
   end

   // external load wins over stall and drops the fetched word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch.valid <= 1'b0;
      end else if (extern_pc_en) begin
         fetch.valid <= 1'b0;
      end else if (!stall) begin
         fetch.valid <= 1'b1;
         fetch.pc    <= pc;
         fetch.inst  <= inst_data;
      end
   end

   assign inst_addr = pc;

   // pc moved off the reset vector
   assign pc_change = (pc != '0);

endmodule

// ==== source/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  looper_pkg::fetch_t     fetch,
   input  looper_pkg::wb_result_t wb,
   output looper_pkg::reg_idx_t   rs1,
   output looper_pkg::reg_idx_t   rs2,
   input  looper_pkg::data_t      rd1,
   input  looper_pkg::data_t      rd2,
   output logic                   stall,
   output looper_pkg::exec_op_t   op
);
   import looper_pkg::*;

   opcode_t   opcode;
   reg_idx_t  rd_idx;
   data_t     imm6;
   data_t     imm8;
   alu_mode_t mode;
   data_t     op_a;
   data_t     op_b;
   logic      use_rs1;
   logic      use_rs2;
   logic      writes;
   logic      issue;
   exec_op_t  op_next;

   // destination still in flight in execute or on the write-back port
   function automatic logic pending(input reg_idx_t idx, input exec_op_t ex,
                                    input wb_result_t res);
      pending = (ex.valid && (ex.rd == idx)) || (res.valid && (res.dst == idx));
   endfunction

   assign opcode = opcode_t'(fetch.inst[15:12]);
   assign rd_idx = fetch.inst[11:9];
   assign rs1    = fetch.inst[8:6];
   assign rs2    = fetch.inst[5:3];
   assign imm6   = data_t'(fetch.inst[5:0]);
   assign imm8   = data_t'(fetch.inst[7:0]);

   always_comb begin
      mode    = alu_pass;
      op_a    = rd1;
      op_b    = rd2;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      writes  = 1'b1;
      case (opcode)
         op_add, op_sub, op_and, op_or, op_xor, op_mul: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            case (opcode)
               op_add:  mode = alu_add;
               op_sub:  mode = alu_sub;
               op_and:  mode = alu_and;
               op_or:   mode = alu_or;
               op_xor:  mode = alu_xor;
               default: mode = alu_mul;
            endcase
         end
         op_addi: begin
            mode    = alu_add;
            op_b    = imm6;
            use_rs1 = 1'b1;
         end
         op_ldi: begin
            op_a = '0;
            op_b = imm8;
         end
         // nop and unused codes retire nothing
         default: writes = 1'b0;
      endcase
   end

   assign stall = fetch.valid &&
                  ((use_rs1 && pending(rs1, op, wb)) || (use_rs2 && pending(rs2, op, wb)));

   // bubble while stalled
   assign issue = fetch.valid && writes && !stall;

   always_comb begin
      op_next.valid = issue;
      op_next.mode  = mode;
      op_next.rd    = rd_idx;
      op_next.op_a  = op_a;
      op_next.op_b  = op_b;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op.valid <= 1'b0;
      end else begin
         op <= op_next;
      end
   end

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  looper_pkg::exec_op_t   op,
   output looper_pkg::wb_result_t result
);
   import looper_pkg::*;

   data_t alu_out;
   data_t product;

   // low half of the 16x16 product
   assign product = op.op_a * op.op_b;

   always_comb begin
      case (op.mode)
         alu_add:  alu_out = op.op_a + op.op_b;
         alu_sub:  alu_out = op.op_a - op.op_b;
         alu_and:  alu_out = op.op_a & op.op_b;
         alu_or:   alu_out = op.op_a | op.op_b;
         alu_xor:  alu_out = op.op_a ^ op.op_b;
         alu_mul:  alu_out = product;
         // ldi lands here with the immediate in op_b
         alu_pass: alu_out = op.op_b;
         default:  alu_out = op.op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         result.valid <= 1'b0;
      end else begin
         result.valid <= op.valid;
         result.dst   <= op.rd;
         result.data  <= alu_out;
      end
   end

endmodule

// ==== source/writeback_regfile.sv ====
`timescale 1ns/1ps

module writeback_regfile (
   input  logic                   clk,
   input  logic                   rst_n,
   input  looper_pkg::wb_result_t wb,
   input  looper_pkg::reg_idx_t   rs1,
   input  looper_pkg::reg_idx_t   rs2,
   output looper_pkg::data_t      rd1,
   output looper_pkg::data_t      rd2
);
   import looper_pkg::*;

   data_t regs [num_regs];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.dst] <= wb.data;
      end
   end

   // write-through so decode sees the result on the cycle it retires
   assign rd1 = (wb.valid && (wb.dst == rs1)) ? wb.data : regs[rs1];
   assign rd2 = (wb.valid && (wb.dst == rs2)) ? wb.data : regs[rs2];

endmodule

// ==== source/looper_top.sv ====
`timescale 1ns/1ps

module looper_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  looper_pkg::pc_t        extern_pc,
   input  logic                   extern_pc_en,
   input  looper_pkg::inst_t      inst_data,
   output looper_pkg::pc_t        inst_addr,
   output logic                   pc_change,
   output looper_pkg::wb_result_t wb
);
   import looper_pkg::*;

   fetch_t   fetch;
   exec_op_t op;
   reg_idx_t rs1;
   reg_idx_t rs2;
   data_t    rd1;
   data_t    rd2;
   logic     stall;

   fetch_unit u_fetch (
      .clk          (clk),
      .rst_n        (rst_n),
      .stall        (stall),
      .extern_pc    (extern_pc),
      .extern_pc_en (extern_pc_en),
      .inst_data    (inst_data),
      .inst_addr    (inst_addr),
      .fetch        (fetch),
      .pc_change    (pc_change)
   );

   // wb also feeds the scoreboard in decode
   decode_unit u_decode (
      .clk   (clk),
      .rst_n (rst_n),
      .fetch (fetch),
      .wb    (wb),
      .rs1   (rs1),
      .rs2   (rs2),
      .rd1   (rd1),
      .rd2   (rd2),
      .stall (stall),
      .op    (op)
   );

   execute_unit u_execute (
      .clk    (clk),
      .rst_n  (rst_n),
      .op     (op),
      .result (wb)
   );

   writeback_regfile u_regfile (
      .clk   (clk),
      .rst_n (rst_n),
      .wb    (wb),
      .rs1   (rs1),
      .rs2   (rs2),
      .rd1   (rd1),
      .rd2   (rd2)
   );

endmodule

// ==== dv/looper_model.svh ====
`ifndef LOOPER_MODEL_SVH
`define LOOPER_MODEL_SVH

// model state and program bookkeeping
data_t      model_regs [num_regs];
wb_result_t expected_q [$];
int         wr_addr;
int         prog_a_len;
int         prog_b_len;
pc_t        jump_pc;

function automatic inst_t enc_alu(input opcode_t opc, input reg_idx_t rd,
                                  input reg_idx_t rs1, input reg_idx_t rs2);
   enc_alu = {opc, rd, rs1, rs2, 3'b000};
endfunction

function automatic inst_t enc_addi(input reg_idx_t rd, input reg_idx_t rs1,
                                   input logic [5:0] imm);
   enc_addi = {op_addi, rd, rs1, imm};
endfunction

// bit 8 is unused by ldi
function automatic inst_t enc_ldi(input reg_idx_t rd, input logic [7:0] imm);
   enc_ldi = {op_ldi, rd, 1'b0, imm};
endfunction

function automatic logic [7:0] rand_byte();
   rand_byte = 8'($random(seed));
endfunction

task automatic emit(input inst_t inst);
   imem[wr_addr] = inst;
   wr_addr++;
endtask

task automatic emit_nops(input int count);
   for (int i = 0; i < count; i++) begin
      emit(enc_alu(op_nop, 0, 0, 0));
   end
endtask

task automatic load_programs();
   for (int i = 0; i < 256; i++) begin
      imem[i] = enc_alu(op_nop, 0, 0, 0);
   end
   wr_addr = 0;
   // independent alu ops behind the loads
   emit(enc_ldi(1, rand_byte()));
   emit(enc_ldi(2, rand_byte()));
   emit(enc_ldi(3, rand_byte()));
   emit(enc_ldi(4, rand_byte()));
   emit_nops(3);
   emit(enc_alu(op_add, 5, 1, 2));
   emit(enc_alu(op_sub, 6, 3, 4));
   emit_nops(1);
   emit(enc_alu(op_and, 7, 1, 3));
   emit(enc_alu(op_or, 0, 2, 4));
   emit_nops(1);
   emit(enc_alu(op_xor, 5, 1, 4));
   // immediates and multiply, r5 product overflows
   emit(enc_ldi(1, 8'hff));
   emit(enc_ldi(2, 8'hfd));
   emit(enc_ldi(0, rand_byte()));
   emit(enc_addi(3, 1, 6'h3f));
   emit(enc_alu(op_mul, 4, 1, 2));
   emit_nops(1);
   emit(enc_alu(op_mul, 5, 4, 4));
   emit(enc_addi(6, 5, 6'h15));
   emit(enc_alu(op_mul, 7, 0, 2));
   // each op reads the previous rd
   emit(enc_ldi(1, rand_byte()));
   emit(enc_alu(op_add, 2, 1, 1));
   emit(enc_alu(op_sub, 3, 2, 1));
   emit(enc_alu(op_xor, 4, 3, 2));
   emit(enc_alu(op_mul, 5, 4, 3));
   emit(enc_alu(op_or, 6, 5, 4));
   emit(enc_alu(op_and, 7, 6, 5));
   emit(enc_addi(7, 7, 6'h01));
   prog_a_len = wr_addr;
   // only runs if the pc load is ignored
   imem[prog_a_len + 8] = enc_ldi(0, 8'h5a);
   jump_pc = 16'h0080;
   wr_addr = jump_pc;
   emit(enc_addi(1, 7, 6'h05));
   emit(enc_ldi(2, rand_byte()));
   emit(enc_alu(op_mul, 3, 1, 2));
   emit(enc_alu(op_xor, 4, 3, 1));
   emit_nops(1);
   emit(enc_alu(op_sub, 5, 4, 2));
   prog_b_len = wr_addr - jump_pc;
endtask

// in-order reference for one instruction
function automatic void model_exec(input inst_t inst);
   opcode_t    opc;
   data_t      a;
   data_t      b;
   wb_result_t res;
   opc       = opcode_t'(inst[15:12]);
   a         = model_regs[inst[8:6]];
   b         = model_regs[inst[5:3]];
   res.valid = 1'b1;
   res.dst   = inst[11:9];
   res.data  = '0;
   case (opc)
      op_add:  res.data = a + b;
      op_sub:  res.data = a - b;
      op_and:  res.data = a & b;
      op_or:   res.data = a | b;
      op_xor:  res.data = a ^ b;
      op_mul:  res.data = a * b;
      op_addi: res.data = a + data_t'(inst[5:0]);
      op_ldi:  res.data = data_t'(inst[7:0]);
      default: res.valid = 1'b0;
   endcase
   if (res.valid) begin
      model_regs[res.dst] = res.data;
      expected_q.push_back(res);
   end
endfunction

task automatic run_model();
   for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
   end
   for (int i = 0; i < prog_a_len; i++) begin
      model_exec(imem[i]);
   end
   for (int i = 0; i < prog_b_len; i++) begin
      model_exec(imem[jump_pc + i]);
   end
endtask

`endif

// ==== dv/looper_tb.sv ====
`timescale 1ns/1ps

module looper_tb;
   import looper_pkg::*;

   logic       clk = 1'b0;
   logic       rst_n;
   pc_t        extern_pc;
   logic       extern_pc_en;
   inst_t      inst_data;
   pc_t        inst_addr;
   logic       pc_change;
   wb_result_t wb;

   inst_t      imem [256];
   integer     seed = 32'h3314_5bd1;
   int         reset_cycles = 5;
   int         prog_len = 0;
   int         checks = 0;
   int         errors = 0;
   logic       started = 1'b0;
   wb_result_t want;

   `include "looper_model.svh"

   looper_top i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .extern_pc    (extern_pc),
      .extern_pc_en (extern_pc_en),
      .inst_data    (inst_data),
      .inst_addr    (inst_addr),
      .pc_change    (pc_change),
      .wb           (wb)
   );

   initial begin
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic check(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("FAIL at %0d ns: %s", $time, what);
      end
   endtask

   // nothing fetched beyond the array
   function automatic inst_t word_at(input pc_t addr);
      if (addr < 16'd256) begin
         word_at = imem[addr[7:0]];
      end else begin
         word_at = '0;
      end
   endfunction

   task automatic wait_for_addr(input pc_t target);
      @(negedge clk);
      while (inst_addr != target) begin
         @(negedge clk);
      end
   endtask

   // instruction memory answers on the falling edge
   always @(negedge clk) begin
      inst_data = word_at(inst_addr);
   end

   always @(negedge clk) begin
      if (started) begin
         check(pc_change == (inst_addr != '0),
               $sformatf("pc_change %b with inst_addr %h", pc_change, inst_addr));
         if (wb.valid) begin
            checks++;
            assert (expected_q.size() != 0) else begin
               errors++;
               $display("unexpected write-back of %h to r%0d at %0d ns, no result pending",
                        wb.data, wb.dst, $time);
            end
            if (expected_q.size() != 0) begin
               want = expected_q.pop_front();
               check((wb.dst == want.dst) && (wb.data == want.data),
                     $sformatf("wb r%0d=%h, expected r%0d=%h",
                               wb.dst, wb.data, want.dst, want.data));
            end
         end
      end
   end

   initial begin
      rst_n        = 1'b0;
      extern_pc    = '0;
      extern_pc_en = 1'b0;
      inst_data    = '0;
      load_programs();
      run_model();
      prog_len = prog_a_len + prog_b_len;
      repeat (reset_cycles) @(negedge clk);
      check(!wb.valid, "wb.valid high in reset");
      check(!pc_change, "pc_change high in reset");
      check(inst_addr == '0, $sformatf("inst_addr %h in reset", inst_addr));
      rst_n = 1'b1;
      @(posedge clk);
      started = 1'b1;

      // redirect while fetch runs through the nops after program a
      wait_for_addr(pc_t'(prog_a_len + 4));
      extern_pc    = jump_pc;
      extern_pc_en = 1'b1;
      @(negedge clk);
      extern_pc_en = 1'b0;
      check(inst_addr == jump_pc,
            $sformatf("inst_addr %h after pc load, expected %h", inst_addr, jump_pc));
      @(negedge clk);
      check(inst_addr == jump_pc + 1,
            $sformatf("inst_addr %h after pc load, expected %h", inst_addr, jump_pc + 1));

      while (expected_q.size() != 0) begin
         @(posedge clk);
      end
      // idle window catches extra results
      repeat (20) @(posedge clk);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      wait (prog_len != 0);
      repeat (prog_len * 10 + reset_cycles) @(posedge clk);
      $display("timeout: test did not finish within %0d cycles, %0d results still missing",
               prog_len * 10 + reset_cycles, expected_q.size());
      $display("checks %0d, errors %0d", checks, errors);
      $display("Finished with errors");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+dv
source/looper_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/writeback_regfile.sv
source/looper_top.sv
dv/looper_tb.sv

// ==== Bender.yml ====
package:
  name: looper

sources:
  - source/looper_pkg.sv
  - source/fetch_unit.sv
  - source/decode_unit.sv
  - source/execute_unit.sv
  - source/writeback_regfile.sv
  - source/looper_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/looper_tb.sv
